// File: Bender.yml
package:
  name: histo

export_include_dirs:
  - .

sources:
  - files:
      - histoPkg.sv
      - hitCapture.sv
      - frameTimer.sv
      - histogramRam.sv
      - binReadout.sv
      - histoTop.sv
  - target: test
    files:
      - histo_asserts.sv
      - histoTb.sv

// File: binReadout.sv
`timescale 1ns/1ps

`include "histo_defines.svh"

// streams the histogram out once the frame is over
module binReadout (
    input  logic               clk,
    input  logic               res,
    input  logic               frameEnd,
    input  histoPkg::binCountT rdCount,
    output logic               rdEn,
    output histoPkg::binAddrT  rdAddr,
    output logic               binValid,
    output histoPkg::binAddrT  binAddr,
    output histoPkg::binCountT binCount,
    output logic               frameDone,
    output logic               readoutDone
);

    import histoPkg::*;

    localparam binAddrT lastAddr  = binAddrT'(`HISTO_BINS - 1);
    localparam binAddrT drainLast = binAddrT'(2);  // three drain cycles

    readoutStateT state;
    binAddrT      idx;  // drain cycle count, then sweep address

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= stIdle;
            idx   <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (frameEnd) begin
                        state <= stDrain;
                        idx   <= '0;
                    end
                end
                stDrain: begin
                    // last hit of the frame needs these cycles to land in the RAM
                    if (idx == drainLast) begin
                        state <= stSweep;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                stSweep: begin
                    if (idx == lastAddr) begin
                        state <= stDone;
                    end
                    idx <= idx + 1'b1;  // wraps to zero after the last bin
                end
                default: state <= stIdle;  // stDone lasts one cycle
            endcase
        end
    end

    assign rdEn   = (state == stSweep);
    assign rdAddr = idx;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid    <= 1'b0;
            frameDone   <= 1'b0;
            readoutDone <= 1'b0;
        end else begin
            binValid    <= rdEn;  // matches RAM read latency
            frameDone   <= (state == stDone);
            readoutDone <= (state == stDone);
        end
    end

    always_ff @(posedge clk) begin
        if (rdEn) begin
            binAddr <= rdAddr;
        end
    end

    assign binCount = rdCount;  // already registered in the RAM

endmodule

// File: frameTimer.sv
`timescale 1ns/1ps

`include "histo_defines.svh"

// acquisition window generator
module frameTimer (
    input  logic clk,
    input  logic res,
    input  logic readoutDone,
    output logic acquiring,
    output logic frameEnd,
    output logic nextFlag
);

    localparam int timerW = $clog2(`HISTO_FRAME_LEN);
    localparam logic [timerW-1:0] lastCycle = timerW'(`HISTO_FRAME_LEN - 1);

    logic [timerW-1:0] cycleCnt;  // cycles elapsed in the window

    // high on the last accepting cycle
    assign frameEnd = acquiring && (cycleCnt == lastCycle);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cycleCnt  <= '0;
            acquiring <= 1'b1;  // first frame opens right out of reset
            nextFlag  <= 1'b0;
        end else if (acquiring) begin
            if (frameEnd) begin
                cycleCnt  <= '0;
                acquiring <= 1'b0;
                nextFlag  <= ~nextFlag;  // marks frame boundary downstream
            end else begin
                cycleCnt <= cycleCnt + 1'b1;
            end
        end else if (readoutDone) begin
            // histogram emptied, next frame starts
            acquiring <= 1'b1;
        end
    end

endmodule

// File: histoPkg.sv
`include "histo_defines.svh"

package histoPkg;

    // time-bin address of a photon hit
    typedef logic [`HISTO_ADDR_W-1:0] binAddrT;

    // number of hits collected in one bin
    typedef logic [`HISTO_COUNT_W-1:0] binCountT;

    // readout sequencer
    typedef enum logic [1:0] {
        stIdle,   // waiting for the end of the frame
        stDrain,  // letting the hit pipeline empty
        stSweep,  // reading bins 0 to last
        stDone    // end of readout
    } readoutStateT;

endpackage

// File: histoTb.sv
`timescale 1ns/1ps

`include "histo_defines.svh"

module histoTb;

    import histoPkg::*;

    logic     clk;
    logic     res;
    logic     hit;
    binAddrT  hitAddr;
    logic     acquiring;
    logic     nextFlag;
    logic     binValid;
    binAddrT  binAddr;
    binCountT binCount;
    logic     frameDone;

    logic [31:0] lfsrState;
    int unsigned model [`HISTO_BINS];  // expected count per bin
    int   expIdx;       // next bin expected from the readout
    int   flagToggles;  // nextFlag edges in the current frame
    int   winCnt;
    int   lastWin;      // length of the last closed window
    logic prevAcq;
    logic prevFlag;
    logic prevDone;
    logic closed;       // window over and frameDone not yet seen
    int   errCnt;
    int   testErr0;
    int   testCnt;
    int   failCnt;

    histoTop dut_i (.*);

    bind histoTop histoAsserts asserts_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // reference model and readout checks on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (!res) begin
            foreach (model[i]) model[i] = 0;
            expIdx = 0;
            flagToggles = 0;
            winCnt = 0;
            prevAcq = 1'b0;
            prevFlag = 1'b0;
            prevDone = 1'b0;
            closed = 1'b0;
        end else begin
            if (hit && acquiring) model[hitAddr] = model[hitAddr] + 1;  // counted at next edge
            if (acquiring) winCnt = winCnt + 1;
            if (prevAcq && !acquiring) begin
                lastWin = winCnt;
                winCnt = 0;
                closed = 1'b1;
            end
            if (acquiring && (closed || binValid)) begin
                errCnt++;
                $display("acquiring was high during drain or readout");
            end
            if (frameDone && prevDone) begin
                errCnt++;
                $display("frameDone stayed high for more than one cycle");
            end
            if (prevDone && !acquiring) begin
                errCnt++;
                $display("acquiring did not reopen on the cycle after frameDone");
            end
            if (nextFlag != prevFlag) flagToggles++;
            prevAcq = acquiring;
            prevFlag = nextFlag;
            prevDone = frameDone;
            if (binValid) begin
                if (expIdx >= `HISTO_BINS) begin
                    errCnt++;
                    $display("binValid seen after the last bin");
                end else if (binAddr !== binAddrT'(expIdx)) begin
                    errCnt++;
                    $display("Error: binAddr got 0x%h expected 0x%h", binAddr, binAddrT'(expIdx));
                end else if (binCount !== binCountT'(model[expIdx])) begin
                    errCnt++;
                    $display("Error: binCount bin 0x%h got 0x%h expected 0x%h",
                             binAddr, binCount, binCountT'(model[expIdx]));
                end
                expIdx++;
            end
            if (frameDone) begin
                foreach (model[i]) model[i] = 0;  // next frame starts empty
                expIdx = 0;
                flagToggles = 0;
                closed = 1'b0;
            end
        end
    end

    // drives hits for one whole acquisition window
    task automatic runWindow(input int mode);
        int         guard;
        int         n;
        int         seg;
        logic [3:0] density;
        binAddrT    base;
        guard = 0;
        n = 0;
        density = 4'(randBits(4));
        while (!acquiring && guard < 200) begin
            @(posedge clk);
            #1;
            guard++;
        end
        while (acquiring && n < `HISTO_FRAME_LEN + 10) begin
            seg = (n >> 3) % 4;
            base = binAddrT'((n >> 5) * 5);
            case (mode)
                0: begin
                    hit = (randBits(4) <= density);
                    hitAddr = binAddrT'(randBits(6));
                end
                1: begin
                    hit = (seg != 3);  // runs of 8, then a gap
                    if (seg == 1) hitAddr = base + binAddrT'(n % 2);
                    else if (seg == 2) hitAddr = base + binAddrT'(((n >> 1) % 2) * 3);
                    else hitAddr = base;
                end
                default: begin
                    hit = (randBits(1) != 0);
                    hitAddr = binAddrT'(5 + 19 * randBits(2));  // bins 5, 24, 43, 62
                end
            endcase
            @(posedge clk);
            #1;
            n++;
        end
        hit = 1'b0;
        if (acquiring || n == 0) begin
            errCnt++;
            $display("acquisition window did not open and close in time");
        end
    endtask

    // waits for the readout to end and checks the frame bookkeeping
    task automatic finishFrame(input string name, input logic busy);
        int guard;
        guard = 0;
        while (!frameDone && guard < 200) begin
            hit = busy;  // these hits must be dropped
            hitAddr = binAddrT'(randBits(6));
            @(posedge clk);
            #1;
            guard++;
        end
        hit = 1'b0;
        if (!frameDone) begin
            errCnt++;
            $display("frameDone did not arrive within 200 cycles");
        end else begin
            if (expIdx != `HISTO_BINS) begin
                errCnt++;
                $display("Error: binValid count 0x%h expected 0x%h", expIdx, `HISTO_BINS);
            end
            if (flagToggles != 1) begin
                errCnt++;
                $display("Error: nextFlag toggles 0x%h expected 0x1", flagToggles);
            end
            if (lastWin != `HISTO_FRAME_LEN) begin
                errCnt++;
                $display("Error: acquiring length 0x%h expected 0x%h", lastWin, `HISTO_FRAME_LEN);
            end
        end
        testCnt++;
        if (errCnt != testErr0) failCnt++;
        $display("test %0d %s: %0d errors", testCnt, name, errCnt - testErr0);
        testErr0 = errCnt;
    endtask

    initial begin
        int guard;
        int k;
        res = 1'b0;
        hit = 1'b0;
        hitAddr = '0;
        lfsrState = 32'h9d5de45b;
        errCnt = 0;
        testErr0 = 0;
        testCnt = 0;
        failCnt = 0;
        lastWin = 0;
        repeat (8) @(posedge clk);
        #1;
        res = 1'b1;

        runWindow(0);
        finishFrame("random hits", 1'b0);
        runWindow(1);
        finishFrame("same-address bursts", 1'b0);
        runWindow(2);
        finishFrame("few bins, lazy clear", 1'b0);
        runWindow(0);
        finishFrame("hits during readout", 1'b1);
        runWindow(0);
        finishFrame("nextFlag and window length", 1'b0);

        // reset somewhere inside the sweep
        runWindow(0);
        guard = 0;
        k = 1 + randBits(5);
        while (expIdx < k && guard < 200) begin
            @(posedge clk);
            #1;
            guard++;
        end
        if (expIdx < k) begin
            errCnt++;
            $display("readout sweep did not start in time");
        end
        res = 1'b0;
        #1;
        if (binValid !== 1'b0 || frameDone !== 1'b0) begin
            errCnt++;
            $display("binValid or frameDone stayed high in reset");
        end
        repeat (3) @(posedge clk);
        #1;
        res = 1'b1;
        runWindow(2);
        finishFrame("reset during sweep", 1'b0);

        $display("tests %0d, failed %0d, errors %0d", testCnt, failCnt, errCnt);
        if (errCnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: histoTop.sv
`timescale 1ns/1ps

// photon-arrival histogram builder
module histoTop (
    input  logic               clk,
    input  logic               res,
    input  logic               hit,
    input  histoPkg::binAddrT  hitAddr,
    output logic               acquiring,
    output logic               nextFlag,
    output logic               binValid,
    output histoPkg::binAddrT  binAddr,
    output histoPkg::binCountT binCount,
    output logic               frameDone
);

    import histoPkg::*;

    logic     frameEnd;
    logic     readoutDone;
    logic     capValid;
    binAddrT  capAddr;
    logic     rdEn;
    binAddrT  rdAddr;
    binCountT rdCount;

    hitCapture capture_i (
        .clk       (clk),
        .res       (res),
        .hit       (hit),
        .hitAddr   (hitAddr),
        .acquiring (acquiring),
        .capValid  (capValid),
        .capAddr   (capAddr)
    );

    frameTimer timer_i (
        .clk         (clk),
        .res         (res),
        .readoutDone (readoutDone),
        .acquiring   (acquiring),
        .frameEnd    (frameEnd),
        .nextFlag    (nextFlag)
    );

    histogramRam ram_i (
        .clk      (clk),
        .res      (res),
        .capValid (capValid),
        .capAddr  (capAddr),
        .rdEn     (rdEn),
        .rdAddr   (rdAddr),
        .rdCount  (rdCount)
    );

    binReadout readout_i (
        .clk         (clk),
        .res         (res),
        .frameEnd    (frameEnd),
        .rdCount     (rdCount),
        .rdEn        (rdEn),
        .rdAddr      (rdAddr),
        .binValid    (binValid),
        .binAddr     (binAddr),
        .binCount    (binCount),
        .frameDone   (frameDone),
        .readoutDone (readoutDone)
    );

endmodule

// File: histo_asserts.sv
`timescale 1ns/1ps

// output protocol checks, bound into histoTop
module histoAsserts (
    input logic              clk,
    input logic              res,
    input logic              acquiring,
    input logic              binValid,
    input histoPkg::binAddrT binAddr,
    input logic              frameDone
);

    import histoPkg::*;

    // readout only while the window is closed
    readoutOutsideWindow: assert property (
        @(posedge clk) disable iff (!res) !(binValid && acquiring)
    ) else $error("binValid high while acquiring");

    donePulse: assert property (
        @(posedge clk) disable iff (!res) frameDone |=> !frameDone
    ) else $error("frameDone longer than one cycle");

    // sweep runs through the bins in order
    addrStep: assert property (
        @(posedge clk) disable iff (!res)
        binValid && $past(binValid) |-> binAddr == binAddrT'($past(binAddr) + 1'b1)
    ) else $error("binAddr did not step by one");

endmodule

// File: histo_defines.svh
`ifndef HISTO_DEFINES_SVH
`define HISTO_DEFINES_SVH

// histogram geometry

// bin address width that sets the number of bins
`define HISTO_ADDR_W 6

// number of bins, equal to 2**HISTO_ADDR_W
`define HISTO_BINS 64

// per-bin counter width that a frame cannot overflow
`define HISTO_COUNT_W 21

// acquisition window in clock cycles
`define HISTO_FRAME_LEN 300

// readout adds 3 drain cycles, 64 sweep cycles, the done state and the frameDone cycle
// after each window, so one frame period is HISTO_FRAME_LEN + 69 cycles

`endif

// File: histogramRam.sv
`timescale 1ns/1ps

`include "histo_defines.svh"

// bin memory with read-modify-write hit path and a read-and-clear port
module histogramRam (
    input  logic               clk,
    input  logic               res,
    input  logic               capValid,
    input  histoPkg::binAddrT  capAddr,
    input  logic               rdEn,
    input  histoPkg::binAddrT  rdAddr,
    output histoPkg::binCountT rdCount
);

    import histoPkg::*;

    binCountT countMem [`HISTO_BINS];

    // a clear bit means the stored count is stale from an earlier frame
    logic [`HISTO_BINS-1:0] binOk;

    // stage two of the hit path
    logic     s2Valid;
    binAddrT  s2Addr;
    binCountT s2Base;    // count read in stage one
    logic     s2BaseOk;  // valid bit read in stage one
    binCountT s2Next;    // value written back

    logic fwd;

    // stale bins restart at one
    assign s2Next = s2BaseOk ? s2Base + 1'b1 : binCountT'(1);

    // stage two write not yet in the array
    assign fwd = s2Valid && (s2Addr == capAddr);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2Valid <= 1'b0;
        end else begin
            s2Valid <= capValid;
        end
    end

    // stage one, read count and valid bit
    always_ff @(posedge clk) begin
        if (capValid) begin
            s2Addr <= capAddr;
            if (fwd) begin
                s2Base   <= s2Next;  // back-to-back hits on one bin
                s2BaseOk <= 1'b1;
            end else begin
                s2Base   <= countMem[capAddr];
                s2BaseOk <= binOk[capAddr];
            end
        end
    end

    // stage two, write back
    always_ff @(posedge clk) begin
        if (s2Valid) begin
            countMem[s2Addr] <= s2Next;
        end
    end

    // valid bits are the only state that reset touches
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binOk <= '0;
        end else begin
            if (s2Valid) begin
                binOk[s2Addr] <= 1'b1;
            end
            // lazy clear, the bin reads as empty in the next frame
            if (rdEn) begin
                binOk[rdAddr] <= 1'b0;
            end
        end
    end

    // readout port, one cycle latency
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdCount <= binOk[rdAddr] ? countMem[rdAddr] : '0;
        end
    end

endmodule

// File: hitCapture.sv
`timescale 1ns/1ps

// input register for the hit strobe from the timing front end
module hitCapture (
    input  logic              clk,
    input  logic              res,
    input  logic              hit,
    input  histoPkg::binAddrT hitAddr,
    input  logic              acquiring,
    output logic              capValid,
    output histoPkg::binAddrT capAddr
);

    logic accept;

    // hits outside the window never reach the RAM
    assign accept = hit && acquiring;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            capValid <= 1'b0;
        end else begin
            capValid <= accept;  // one cycle behind the hit edge
        end
    end

    // address only follows accepted hits
    always_ff @(posedge clk) begin
        if (accept) begin
            capAddr <= hitAddr;
        end
    end

endmodule

// File: project.f
+incdir+.
histoPkg.sv
hitCapture.sv
frameTimer.sv
histogramRam.sv
binReadout.sv
histoTop.sv
histo_asserts.sv
histoTb.sv
